/* design/cache_pkg.sv */
// cache package: geometry constants and the line and request structs

package cache_pkg;

	// geometry
	localparam int num_sets  = 8;
	localparam int num_ways  = 4;
	localparam int set_bits  = 3;
	localparam int way_bits  = 2;
	localparam int tag_bits  = 8;
	localparam int data_bits = 64;

	// tree pseudo-LRU: one node per internal branch
	localparam int plru_bits = num_ways - 1;

	typedef logic [way_bits-1:0] way_t;

	// one stored line, 73 bits
	typedef struct packed {
		logic                 valid;
		logic [tag_bits-1:0]  tag;
		logic [data_bits-1:0] data;
	} cache_line_t;

	// read lookup, 11 bits
	typedef struct packed {
		logic [set_bits-1:0] idx;
		logic [tag_bits-1:0] tag;
	} rd_req_t;

	// write fill or update, 75 bits
	typedef struct packed {
		logic [set_bits-1:0]  idx;
		logic [tag_bits-1:0]  tag;
		logic [data_bits-1:0] data;
	} wr_req_t;

endpackage

/* design/tag_match.sv */
// tag match: compares a set's valid tags against a lookup tag and encodes the hit way

`timescale 1ns/100ps

module tag_match import cache_pkg::*; (
	input  cache_line_t [num_ways-1:0] set_lines,
	input  logic [tag_bits-1:0]        tag,
	output logic                       hit,
	output way_t                       way
);

	logic [num_ways-1:0] match;

	// invalid lines never count, even with a stale matching tag
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			match[w] = set_lines[w].valid && (set_lines[w].tag == tag);
		end
	end

	assign hit = |match;

	// at most one way should match; lowest wins if not
	always_comb begin
		way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (match[w]) begin
				way = way_t'(w);
			end
		end
	end

endmodule

/* design/plru_tree.sv */
// plru tree: per-set tree pseudo-LRU state, touch updates and victim way selection

`timescale 1ns/100ps

module plru_tree import cache_pkg::*; (
	input  logic                clock,
	input  logic                reset,

	input  logic                rd_touch,
	input  logic [set_bits-1:0] rd_touch_idx,
	input  way_t                rd_touch_way,

	input  logic                wr_touch,
	input  logic [set_bits-1:0] wr_touch_idx,
	input  way_t                wr_touch_way,

	input  logic [set_bits-1:0] victim_idx,
	output way_t                victim_way
);

	// bit 0 root, bit 1 node over ways 0/1, bit 2 node over ways 2/3
	logic [plru_bits-1:0] tree      [num_sets];
	logic [plru_bits-1:0] tree_next [num_sets];
	logic [plru_bits-1:0] vic_bits;

	// point every node on the path away from the touched way
	function automatic logic [plru_bits-1:0] touch(
		input logic [plru_bits-1:0] bits,
		input way_t                 w
	);
		logic [plru_bits-1:0] nb;
		nb = bits;
		nb[0] = ~w[1];
		if (w[1]) begin
			nb[2] = ~w[0];
		end else begin
			nb[1] = ~w[0];
		end
		return nb;
	endfunction

	// write first, read on top, also when both hit the same set
	always_comb begin
		tree_next = tree;
		if (wr_touch) begin
			tree_next[wr_touch_idx] = touch(tree_next[wr_touch_idx], wr_touch_way);
		end
		if (rd_touch) begin
			tree_next[rd_touch_idx] = touch(tree_next[rd_touch_idx], rd_touch_way);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				tree[s] <= '0;
			end
		end else begin
			tree <= tree_next;
		end
	end

	// walk from the root, 0 left and 1 right
	assign vic_bits = tree[victim_idx];

	always_comb begin
		if (!vic_bits[0]) begin
			victim_way = {1'b0, vic_bits[1]};
		end else begin
			victim_way = {1'b1, vic_bits[2]};
		end
	end

endmodule

/* design/cache_array.sv */
// cache array: line storage with read lookup, write hit or fill, way allocation and victim out

`timescale 1ns/100ps

module cache_array import cache_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	input  logic                 rd_en,
	input  rd_req_t              rd_req,
	input  logic                 wr_en,
	input  wr_req_t              wr_req,
	input  way_t                 plru_way,

	output logic [data_bits-1:0] rd_data,
	output logic                 rd_hit,
	output logic                 rd_miss,
	output logic                 wr_miss,

	output logic                 victim_valid,
	output cache_line_t          victim,
	output logic [set_bits-1:0]  victim_idx,

	output logic                 rd_touch,
	output way_t                 rd_touch_way,
	output way_t                 wr_touch_way
);

	cache_line_t [num_ways-1:0] lines [num_sets];

	cache_line_t [num_ways-1:0] rd_set;
	cache_line_t [num_ways-1:0] wr_set;

	logic rd_lookup_hit;
	way_t rd_way;

	logic wr_lookup_hit;
	way_t wr_hit_way;

	logic has_invalid;
	way_t invalid_way;
	way_t wr_way;

	cache_line_t wr_line;

	assign rd_set = lines[rd_req.idx];
	assign wr_set = lines[wr_req.idx];

	tag_match rd_match (
		.set_lines (rd_set),
		.tag       (rd_req.tag),
		.hit       (rd_lookup_hit),
		.way       (rd_way)
	);

	tag_match wr_match (
		.set_lines (wr_set),
		.tag       (wr_req.tag),
		.hit       (wr_lookup_hit),
		.way       (wr_hit_way)
	);

	// read side, all combinational on the pre-edge contents
	assign rd_data = rd_set[rd_way].data;
	assign rd_hit  = rd_en & rd_lookup_hit;
	assign rd_miss = rd_en & ~rd_lookup_hit;

	assign rd_touch     = rd_en & rd_lookup_hit;
	assign rd_touch_way = rd_way;

	// lowest invalid way in the write set
	always_comb begin
		has_invalid = 1'b0;
		invalid_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!wr_set[w].valid) begin
				has_invalid = 1'b1;
				invalid_way = way_t'(w);
			end
		end
	end

	// hit way, else a free way, else the tree's pick
	always_comb begin
		if (wr_lookup_hit) begin
			wr_way = wr_hit_way;
		end else if (has_invalid) begin
			wr_way = invalid_way;
		end else begin
			wr_way = plru_way;
		end
	end

	assign wr_touch_way = wr_way;
	assign wr_miss      = wr_en & ~wr_lookup_hit;

	// displaced line goes out for the victim buffer
	assign victim       = wr_set[wr_way];
	assign victim_idx   = wr_req.idx;
	assign victim_valid = wr_miss & wr_set[wr_way].valid;

	always_comb begin
		wr_line.valid = 1'b1;
		wr_line.tag   = wr_req.tag;
		wr_line.data  = wr_req.data;
	end

	// reset invalidates every line
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				for (int w = 0; w < num_ways; w++) begin
					lines[s][w].valid <= 1'b0;
				end
			end
		end else if (wr_en) begin
			lines[wr_req.idx][wr_way] <= wr_line;
		end
	end

endmodule

/* design/cache_top.sv */
// cache top: set-associative data cache, line array plus tree pseudo-LRU

`timescale 1ns/100ps

module cache_top import cache_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	input  logic                 rd_en,
	input  rd_req_t              rd_req,
	input  logic                 wr_en,
	input  wr_req_t              wr_req,

	output logic [data_bits-1:0] rd_data,
	output logic                 rd_hit,
	output logic                 rd_miss,
	output logic                 wr_miss,

	output logic                 victim_valid,
	output cache_line_t          victim,
	output logic [set_bits-1:0]  victim_idx
);

	logic rd_touch;
	way_t rd_touch_way;
	way_t wr_touch_way;
	way_t plru_way;

	cache_array cache_array_inst (
		.clock        (clock),
		.reset        (reset),
		.rd_en        (rd_en),
		.rd_req       (rd_req),
		.wr_en        (wr_en),
		.wr_req       (wr_req),
		.plru_way     (plru_way),
		.rd_data      (rd_data),
		.rd_hit       (rd_hit),
		.rd_miss      (rd_miss),
		.wr_miss      (wr_miss),
		.victim_valid (victim_valid),
		.victim       (victim),
		.victim_idx   (victim_idx),
		.rd_touch     (rd_touch),
		.rd_touch_way (rd_touch_way),
		.wr_touch_way (wr_touch_way)
	);

	// every write touches its way, hit or fill
	plru_tree plru_tree_inst (
		.clock        (clock),
		.reset        (reset),
		.rd_touch     (rd_touch),
		.rd_touch_idx (rd_req.idx),
		.rd_touch_way (rd_touch_way),
		.wr_touch     (wr_en),
		.wr_touch_idx (wr_req.idx),
		.wr_touch_way (wr_touch_way),
		.victim_idx   (wr_req.idx),
		.victim_way   (plru_way)
	);

endmodule

/* dv/cache_properties.sv */
// cache properties: concurrent checks on the cache top-level strobes and levels

`timescale 1ns/100ps

module cache_properties (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input logic wr_en,
	input logic rd_hit,
	input logic rd_miss,
	input logic wr_miss,
	input logic victim_valid
);

	// a victim only comes out of a write that missed
	victim_needs_write_miss: assert property (@(posedge clock) disable iff (reset)
		victim_valid |-> (wr_en && wr_miss)) else $error("victim_valid without a write miss");

	hit_miss_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(rd_hit && rd_miss)) else $error("rd_hit and rd_miss high together");

	miss_needs_read: assert property (@(posedge clock) disable iff (reset)
		rd_miss |-> rd_en) else $error("rd_miss without rd_en");

	quiet_in_reset: assert property (@(posedge clock)
		reset |-> !(rd_hit || rd_miss || wr_miss || victim_valid))
		else $error("strobe high during reset");

endmodule

bind cache_top cache_properties cache_properties_inst (.*);

/* dv/cache_tb.sv */
// cache testbench: directed and random traffic checked against a reference cache model

`timescale 1ns/100ps

module cache_tb import cache_pkg::*; ;

	logic clock;
	logic reset;
	logic rd_en;
	rd_req_t rd_req;
	logic wr_en;
	wr_req_t wr_req;
	logic [data_bits-1:0] rd_data;
	logic rd_hit;
	logic rd_miss;
	logic wr_miss;
	logic victim_valid;
	cache_line_t victim;
	logic [set_bits-1:0] victim_idx;

	// reference state
	cache_line_t model_lines [num_sets][num_ways];
	logic [plru_bits-1:0] model_tree [num_sets];

	integer seed = 32'ha0573c82;
	int error_count = 0;
	int test_errors = 0;
	int checked_cycles = 0;

	cache_top cache_top_inst (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic int lookup_way(input logic [set_bits-1:0] idx,
			input logic [tag_bits-1:0] tag);
		int found;
		found = -1;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (model_lines[idx][w].valid && model_lines[idx][w].tag == tag)
				found = w;
		end
		return found;
	endfunction

	// follow the tree from the root, 0 left and 1 right
	function automatic way_t replace_way(input logic [plru_bits-1:0] bits);
		if (bits[0] == 1'b0)
			return bits[1] ? way_t'(1) : way_t'(0);
		return bits[2] ? way_t'(3) : way_t'(2);
	endfunction

	function automatic logic [plru_bits-1:0] point_away(input logic [plru_bits-1:0] bits,
			input way_t w);
		logic [plru_bits-1:0] nb;
		nb = bits;
		case (w)
			2'd0: nb = {nb[2], 2'b11};
			2'd1: nb = {nb[2], 2'b01};
			2'd2: nb = {1'b1, nb[1], 1'b0};
			default: nb = {1'b0, nb[1], 1'b0};
		endcase
		return nb;
	endfunction

	// hit way, else lowest free way, else the tree's pick
	function automatic way_t choose_way(input logic [set_bits-1:0] idx,
			input logic [tag_bits-1:0] tag);
		int hit_w;
		hit_w = lookup_way(idx, tag);
		if (hit_w >= 0)
			return way_t'(hit_w);
		for (int w = 0; w < num_ways; w++) begin
			if (!model_lines[idx][w].valid)
				return way_t'(w);
		end
		return replace_way(model_tree[idx]);
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		error_count++;
	endtask

	task automatic compare_and_advance();
		int rd_w;
		int wr_hit_w;
		way_t wr_w;
		logic exp_rd_hit;
		logic exp_wr_miss;
		logic exp_vv;
		cache_line_t old_line;
		rd_w = lookup_way(rd_req.idx, rd_req.tag);
		wr_hit_w = lookup_way(wr_req.idx, wr_req.tag);
		wr_w = choose_way(wr_req.idx, wr_req.tag);
		old_line = model_lines[wr_req.idx][wr_w];
		exp_rd_hit = rd_en && (rd_w >= 0);
		exp_wr_miss = wr_en && (wr_hit_w < 0);
		exp_vv = exp_wr_miss && old_line.valid;
		if (rd_hit !== exp_rd_hit)
			report_mismatch("rd_hit", rd_hit, exp_rd_hit);
		if (rd_miss !== (rd_en && rd_w < 0))
			report_mismatch("rd_miss", rd_miss, rd_en && rd_w < 0);
		if (exp_rd_hit && rd_data !== model_lines[rd_req.idx][rd_w].data)
			report_mismatch("rd_data", rd_data, model_lines[rd_req.idx][rd_w].data);
		if (wr_miss !== exp_wr_miss)
			report_mismatch("wr_miss", wr_miss, exp_wr_miss);
		if (victim_valid !== exp_vv)
			report_mismatch("victim_valid", victim_valid, exp_vv);
		if (exp_vv && victim !== old_line)
			report_mismatch("victim", victim, old_line);
		if (exp_vv && victim_idx !== wr_req.idx)
			report_mismatch("victim_idx", victim_idx, wr_req.idx);
		// write touch first, read touch on top
		if (wr_en) begin
			model_lines[wr_req.idx][wr_w] = {1'b1, wr_req.tag, wr_req.data};
			model_tree[wr_req.idx] = point_away(model_tree[wr_req.idx], wr_w);
		end
		if (exp_rd_hit)
			model_tree[rd_req.idx] = point_away(model_tree[rd_req.idx], way_t'(rd_w));
		checked_cycles++;
	endtask

	// compare at the falling edge, where inputs and outputs are settled
	always @(negedge clock) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				model_tree[s] = '0;
				for (int w = 0; w < num_ways; w++)
					model_lines[s][w].valid = 1'b0;
			end
		end else begin
			compare_and_advance();
		end
	end

	task automatic drive_cycle(input logic r_en, input logic [set_bits-1:0] r_idx,
			input logic [tag_bits-1:0] r_tag, input logic w_en,
			input logic [set_bits-1:0] w_idx, input logic [tag_bits-1:0] w_tag,
			input logic [data_bits-1:0] w_data);
		@(posedge clock);
		rd_en <= r_en;
		rd_req <= {r_idx, r_tag};
		wr_en <= w_en;
		wr_req <= {w_idx, w_tag, w_data};
	endtask

	task automatic read_line(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag);
		drive_cycle(1'b1, idx, tag, 1'b0, '0, '0, '0);
	endtask

	task automatic write_line(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag);
		drive_cycle(1'b0, '0, '0, 1'b1, idx, tag, {$random(seed), $random(seed)});
	endtask

	// random enables and sets, tags 8'h60 to 8'h67
	task automatic random_cycle();
		logic [31:0] rd_rnd;
		logic [31:0] wr_rnd;
		rd_rnd = $random(seed);
		wr_rnd = $random(seed);
		drive_cycle(rd_rnd[0], rd_rnd[3:1], {5'b01100, rd_rnd[6:4]},
			wr_rnd[0], wr_rnd[3:1], {5'b01100, wr_rnd[6:4]},
			{$random(seed), $random(seed)});
	endtask

	// one idle cycle to close a test
	task automatic end_test(input string name);
		drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
		$display("test %s done, %0d errors", name, error_count - test_errors);
		test_errors = error_count;
	endtask

	initial begin
		int waited;
		waited = 0;
		while (waited < 20000) begin
			@(posedge clock);
			waited++;
		end
		$display("timeout: run did not complete in time");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		rd_en = 1'b0;
		rd_req = '0;
		wr_en = 1'b0;
		wr_req = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		for (int s = 0; s < num_sets; s++)
			read_line(s, 8'h11);
		end_test("reset_miss");

		for (int t = 0; t < 4; t++)
			write_line(3'd3, 8'h10 + t);
		for (int t = 0; t < 4; t++)
			read_line(3'd3, 8'h10 + t);
		end_test("fill_empty");

		write_line(3'd3, 8'h12);
		read_line(3'd3, 8'h12);
		end_test("write_hit");

		// touch ways 3, 0, 2, 1 then evict
		read_line(3'd3, 8'h13);
		read_line(3'd3, 8'h10);
		read_line(3'd3, 8'h12);
		read_line(3'd3, 8'h11);
		write_line(3'd3, 8'h20);
		for (int t = 0; t < 4; t++)
			read_line(3'd3, 8'h10 + t);
		read_line(3'd3, 8'h20);
		end_test("replacement");

		for (int t = 0; t < 4; t++)
			write_line(3'd5, 8'h30 + t);
		drive_cycle(1'b1, 3'd5, 8'h31, 1'b1, 3'd5, 8'h31, {$random(seed), $random(seed)});
		read_line(3'd5, 8'h31);
		drive_cycle(1'b1, 3'd5, 8'h30, 1'b1, 3'd5, 8'h33, {$random(seed), $random(seed)});
		write_line(3'd5, 8'h40);
		write_line(3'd5, 8'h41);
		end_test("same_cycle");

		for (int c = 0; c < 400; c++)
			random_cycle();
		end_test("random_traffic");

		$display("checked %0d cycles, %0d errors", checked_cycles, error_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* flist.f */
design/cache_pkg.sv
design/tag_match.sv
design/plru_tree.sv
design/cache_array.sv
design/cache_top.sv
dv/cache_properties.sv
dv/cache_tb.sv
